// File: list.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/lsu_pkg.sv
rtl/mem_decode.sv
rtl/addr_exec.sv
rtl/lsu_axi.sv
rtl/load_result.sv
rtl/lsu_top.sv
tests/tb_lsu_top.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_lsu_top
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o sim_$(TOP)
	@out="$$(./$(OBJDIR)/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf $(OBJDIR)

// File: tests/tb_lsu_top.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module tb_lsu_top
    import lsu_pkg::*;
();
    localparam int NUM_INSTR = 260;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic [3:0]  strb;
        logic [31:0] data;
    } wr_exp_s;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } rd_exp_s;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        in_valid = 1'b0;
    logic [31:0] inst = 32'd0;
    logic [31:0] rs1_val = 32'd0;
    logic [31:0] rs2_val = 32'd0;
    logic        in_ready, wb_valid, wb_we, wb_fault, wb_illegal;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data, araddr, awaddr, wdata;
    logic [3:0]  arid, awid, wstrb;
    logic [7:0]  arlen, awlen;
    logic [2:0]  arsize, awsize;
    logic [1:0]  arburst, awburst;
    logic        arvalid, rready, awvalid, wlast, wvalid, bready;
    logic        arready = 1'b0;
    logic [31:0] rdata = 32'd0;
    logic [1:0]  rresp = 2'b00;
    logic        rlast = 1'b1;
    logic [3:0]  rid = 4'd0;
    logic        rvalid = 1'b0;
    logic        awready = 1'b0;
    logic        wready = 1'b0;
    logic [1:0]  bresp = 2'b00;
    logic [3:0]  bid = 4'd0;
    logic        bvalid = 1'b0;

    logic [7:0]  mem [logic [31:0]];
    logic [7:0]  shadow [logic [31:0]];
    wb_s         exp_q [$];
    wr_exp_s     wr_q [$];
    rd_exp_s     rd_q [$];
    int          errors = 0, tests = 0, tests_failed = 0, test_err0 = 0;
    int          bus_seen = 0, bus_exp = 0;
    int          ar_cnt = 0, r_cnt = 0, aw_cnt = 0, b_cnt = 0;
    logic        r_pend = 1'b0, b_pend = 1'b0;
    logic [31:0] rd_addr = 32'd0;
    logic [1:0]  b_resp_q = 2'b00;
    logic [2:0]  ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

    always #4 clk = ~clk;

    lsu_top i_lsu_top (.*);

    // unwritten bytes read back a pattern of the whole address.
    function automatic logic [7:0] fill_byte(logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] mem_byte(logic [31:0] a);
        return mem.exists(a) ? mem[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] shadow_byte(logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    function automatic logic in_fault(logic [31:0] a);
        return a >= 32'h0000_F000 && a <= 32'h0000_FFFF;
    endfunction

    function automatic logic [1:0] exp_burst(logic [31:0] a);
        return (a >= 32'hA000_0000 && a <= 32'hBFFF_FFFF) ? 2'b01 : 2'b00;
    endfunction

    function automatic logic [31:0] enc_load(logic [2:0] f3, logic [4:0] rd, logic [11:0] imm);
        return {imm, 5'd1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_store(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, act, exp);
        end
    endtask

    // expected writeback; stores land in the shadow at issue.
    function automatic wb_s ref_lsu(logic [31:0] i, logic [31:0] a, logic [31:0] d);
        wb_s         e;
        logic [2:0]  f3;
        logic        ld, st, flt;
        logic [31:0] imm, addr, base, word, val, lanes;
        logic [3:0]  strb;
        e = '0;
        f3 = i[14:12];
        ld = (i[6:0] == 7'b0000011) && (f3 != 3'd3) && (f3 < 3'd6);
        st = (i[6:0] == 7'b0100011) && (f3 < 3'd3);
        imm = ld ? {{20{i[31]}}, i[31:20]} : {{20{i[31]}}, i[31:25], i[11:7]};
        addr = a + imm;
        base = {addr[31:2], 2'b00};
        flt = (ld || st) && in_fault(addr);
        e.illegal = !(ld || st);
        e.fault = flt;
        if (ld || st) begin
            bus_exp++;
        end
        if (ld) begin
            e.rd = i[11:7];
            rd_q.push_back('{addr: addr, size: {1'b0, f3[1:0]}});
            word = {shadow_byte(base + 3), shadow_byte(base + 2),
                    shadow_byte(base + 1), shadow_byte(base)};
            val = word >> (8 * addr[1:0]);
            case (f3)
                3'd0: val = {{24{val[7]}}, val[7:0]};
                3'd1: val = {{16{val[15]}}, val[15:0]};
                3'd4: val = {24'd0, val[7:0]};
                3'd5: val = {16'd0, val[15:0]};
                default: ;
            endcase
            e.data = flt ? 32'd0 : val;
            e.rd_we = !flt && (e.rd != 5'd0);
        end
        if (st) begin
            strb = (f3 == 3'd0) ? 4'b0001 << addr[1:0] :
                   (f3 == 3'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
            lanes = d << (8 * addr[1:0]);
            wr_q.push_back('{addr: addr, size: f3, strb: strb, data: lanes});
            for (int k = 0; k < 4; k++) begin
                if (strb[k] && !flt) begin
                    shadow[base + k] = lanes[8*k +: 8];
                end
            end
        end
        return e;
    endfunction

    // axi slave with random ready and response delays.
    always @(posedge clk) begin : bus_model
        wr_exp_s     we;
        rd_exp_s     re;
        logic [31:0] mask;
        logic [31:0] base;
        if (!rst) begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                bus_seen++;
                check_val("arlen", 32'(arlen), 32'd0);
                check_val("arburst", 32'(arburst), 32'(exp_burst(araddr)));
                check_val("arid", 32'(arid), 32'(`LSU_AXI_ID));
                if (rd_q.size() == 0) begin
                    errors++;
                    $display("a read appeared on the bus with no load issued");
                end else begin
                    re = rd_q.pop_front();
                    check_val("araddr", araddr, re.addr);
                    check_val("arsize", 32'(arsize), 32'(re.size));
                end
                rd_addr <= araddr;
                r_cnt <= $urandom_range(0, 3);
                r_pend <= 1'b1;
            end else if (arvalid) begin
                if (ar_cnt == 0) begin
                    arready <= 1'b1;
                    ar_cnt <= $urandom_range(0, 3);
                end else begin
                    ar_cnt <= ar_cnt - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pend && !rvalid) begin
                if (r_cnt == 0) begin
                    base = {rd_addr[31:2], 2'b00};
                    rdata <= {mem_byte(base + 3), mem_byte(base + 2),
                              mem_byte(base + 1), mem_byte(base)};
                    rresp <= in_fault(rd_addr) ? 2'b10 : 2'b00; // slverr.
                    rvalid <= 1'b1;
                    r_pend <= 1'b0;
                end else begin
                    r_cnt <= r_cnt - 1;
                end
            end
            if (awvalid && awready && wvalid && wready) begin
                awready <= 1'b0;
                wready <= 1'b0;
                bus_seen++;
                check_val("awlen", 32'(awlen), 32'd0);
                check_val("awburst", 32'(awburst), 32'(exp_burst(awaddr)));
                check_val("awid", 32'(awid), 32'(`LSU_AXI_ID));
                check_val("wlast", 32'(wlast), 32'd1);
                for (int k = 0; k < 4; k++) begin
                    mask[8*k +: 8] = {8{wstrb[k]}};
                end
                if (wr_q.size() == 0) begin
                    errors++;
                    $display("a write appeared on the bus with no store issued");
                end else begin
                    we = wr_q.pop_front();
                    check_val("awaddr", awaddr, we.addr);
                    check_val("awsize", 32'(awsize), 32'(we.size));
                    check_val("wstrb", 32'(wstrb), 32'(we.strb));
                    check_val("wdata", wdata & mask, we.data & mask);
                end
                base = {awaddr[31:2], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    if (wstrb[k] && !in_fault(awaddr)) begin
                        mem[base + k] = wdata[8*k +: 8];
                    end
                end
                b_resp_q <= in_fault(awaddr) ? 2'b10 : 2'b00;
                b_cnt <= $urandom_range(0, 3);
                b_pend <= 1'b1;
            end else if (awvalid && wvalid) begin
                if (aw_cnt == 0) begin
                    awready <= 1'b1; // both channels accept together.
                    wready <= 1'b1;
                    aw_cnt <= $urandom_range(0, 3);
                end else begin
                    aw_cnt <= aw_cnt - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_cnt == 0) begin
                    bresp <= b_resp_q;
                    bvalid <= 1'b1;
                    b_pend <= 1'b0;
                end else begin
                    b_cnt <= b_cnt - 1;
                end
            end
        end
    end

    always @(posedge clk) begin : wb_compare
        wb_s e;
        if (!rst && wb_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a writeback pulse arrived with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                check_val("wb_rd", 32'(wb_rd), 32'(e.rd));
                check_val("wb_we", 32'(wb_we), 32'(e.rd_we));
                check_val("wb_data", wb_data, e.data);
                check_val("wb_fault", 32'(wb_fault), 32'(e.fault));
                check_val("wb_illegal", 32'(wb_illegal), 32'(e.illegal));
            end
        end
    end

    task automatic issue(input logic [31:0] i, input logic [31:0] a, input logic [31:0] d,
                         input int gap);
        in_valid <= 1'b1;
        inst <= i;
        rs1_val <= a;
        rs2_val <= d;
        do @(posedge clk); while (!in_ready);
        exp_q.push_back(ref_lsu(i, a, d));
        if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        check_val("bus transactions", bus_seen, bus_exp);
        tests++;
        if (errors != test_err0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests, name, (errors == test_err0) ? "ok" : "FAIL");
        test_err0 = errors;
    endtask

    initial begin
        int          kind;
        logic [31:0] base;
        logic [31:0] i;
        logic [11:0] imm;
        void'($urandom(80));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // fill bytes here have the top bit set, so extension shows.
        for (int w = 0; w < 5; w++) begin
            for (int off = 0; off < 4; off++) begin
                issue(enc_load(ld_f3[w], 5'(off + 4), 12'(off)), 32'h1080 + 32'(w * 16), 0, 0);
            end
        end
        finish_test("loads");

        for (int off = 0; off < 4; off++) begin
            issue(enc_store(3'd0, 12'(off)), 32'h3000, $urandom, 1);
            issue(enc_load(3'd2, 5'd6, 12'd0), 32'h3000, 0, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(enc_store(3'd1, 12'(off)), 32'h3010, $urandom, 0);
            issue(enc_load(3'd2, 5'd7, 12'd0), 32'h3010, 0, 0);
        end
        issue(enc_store(3'd2, 12'd4), 32'h3000, 32'hCAFE_F00D, 0);
        issue(enc_load(3'd2, 5'd8, 12'd4), 32'h3000, 0, 0);
        finish_test("stores");

        issue(enc_load(3'd2, 5'd9, 12'd16), 32'hA000_0000, 0, 0);
        issue(enc_store(3'd2, 12'd32), 32'hA000_0000, 32'h1234_5678, 0);
        issue(enc_load(3'd2, 5'd9, 12'd0), 32'hBFFF_FFF0, 0, 1);
        issue(enc_load(3'd2, 5'd9, 12'd0), 32'h2000, 0, 0);
        issue(enc_store(3'd1, 12'd4), 32'h2000, 32'h0000_BEEF, 0);
        issue(enc_load(3'd0, 5'd9, 12'd0), 32'hC000_0000, 0, 0);
        finish_test("burst");

        issue(enc_load(3'd2, 5'd7, 12'd16), 32'hF000, 0, 0);
        issue(enc_store(3'd0, 12'd33), 32'hF000, 32'h55, 0);
        issue(enc_load(3'd1, 5'd7, 12'hFFE), 32'hF000, 0, 0); // just below the window.
        finish_test("fault");

        issue(32'h0020_8033, 32'h1000, 0, 0);
        issue(enc_load(3'd3, 5'd3, 12'd0), 32'h1000, 0, 0);
        issue(enc_store(3'd3, 12'd0), 32'h1000, 32'hFFFF_FFFF, 0);
        finish_test("illegal");

        for (int n = 0; n < 200; n++) begin
            kind = $urandom_range(0, 7);
            case ($urandom_range(0, 2))
                0:       base = 32'h0000_1000;
                1:       base = 32'hA000_0100;
                default: base = 32'h0000_F000;
            endcase
            imm = 12'($urandom_range(0, 127)) - 12'd64;
            if (kind < 5) begin
                i = enc_load(ld_f3[kind], 5'($urandom_range(0, 31)), imm);
            end else if (kind < 7) begin
                i = enc_store(3'($urandom_range(0, 2)), imm);
            end else begin
                i = $urandom_range(0, 1) ? 32'h0020_8033 : enc_load(3'd6, 5'd1, imm);
            end
            issue(i, base + 32'd128, $urandom, $urandom_range(0, 2));
        end
        finish_test("random");

        $display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(NUM_INSTR * 40 * 8);
        $display("timeout: instructions still outstanding after %0d cycles", NUM_INSTR * 40);
        $display("Test failed");
        $finish;
    end

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/1ns

module lsu_top
    import axi_pkg::*, lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] inst,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic        wb_we,
    output logic [31:0] wb_data,
    output logic        wb_fault,
    output logic        wb_illegal,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [3:0]  awid,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic [1:0]  bresp,
    input  logic [3:0]  bid,
    input  logic        bvalid,
    output logic        bready
);
    logic      dec_valid;
    logic      dec_ready;
    dec_ctrl_s dec;
    logic      exe_valid;
    logic      exe_ready;
    exe_req_s  exe_req;
    logic      rsp_valid;
    mem_rsp_s  rsp;
    wb_s       wb;
    axi_ar_s   ar;
    axi_r_s    r;
    axi_aw_s   aw;
    axi_w_s    w;
    axi_b_s    b;

    assign araddr  = ar.addr;
    assign arid    = ar.id;
    assign arlen   = ar.len;
    assign arsize  = ar.size;
    assign arburst = ar.burst;
    assign awaddr  = aw.addr;
    assign awid    = aw.id;
    assign awlen   = aw.len;
    assign awsize  = aw.size;
    assign awburst = aw.burst;
    assign wdata   = w.data;
    assign wstrb   = w.strb;
    assign wlast   = w.last;
    assign r       = '{data: rdata, resp: rresp, last: rlast, id: rid};
    assign b       = '{resp: bresp, id: bid};

    assign wb_rd      = wb.rd;
    assign wb_we      = wb.rd_we;
    assign wb_data    = wb.data;
    assign wb_fault   = wb.fault;
    assign wb_illegal = wb.illegal;

    mem_decode i_mem_decode (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready),
        .inst(inst), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .dec(dec)
    );

    addr_exec i_addr_exec (
        .clk(clk), .rst(rst),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .dec(dec),
        .exe_valid(exe_valid), .exe_ready(exe_ready), .req(exe_req)
    );

    lsu_axi i_lsu_axi (
        .clk(clk), .rst(rst),
        .exe_valid(exe_valid), .exe_ready(exe_ready), .req(exe_req),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready)
    );

    load_result i_load_result (
        .clk(clk), .rst(rst),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .wb_valid(wb_valid), .wb(wb)
    );

endmodule

// File: rtl/load_result.sv
`timescale 1ns/1ns

module load_result
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rsp_valid,
    input  mem_rsp_s rsp,
    output logic     wb_valid,
    output wb_s      wb
);
    logic [31:0] shifted;
    logic [31:0] ext;
    logic        load_ok;

    assign shifted = rsp.rdata >> {rsp.offset, 3'b000}; // addressed lane to bit 0.
    assign load_ok = rsp.is_load && !rsp.fault;

    always_comb begin
        case (rsp.width)
            MW_BYTE: begin
                if (rsp.is_unsigned) begin
                    ext = {24'd0, shifted[7:0]};
                end else begin
                    ext = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            MW_HALF: begin
                if (rsp.is_unsigned) begin
                    ext = {16'd0, shifted[15:0]};
                end else begin
                    ext = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: ext = shifted;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            wb.rd      <= rsp.rd;
            wb.rd_we   <= load_ok && (rsp.rd != 5'd0); // x0 never written.
            wb.data    <= load_ok ? ext : 32'd0;
            wb.fault   <= rsp.fault;
            wb.illegal <= rsp.illegal;
        end
    end

endmodule

// File: rtl/lsu_axi.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_axi
    import axi_pkg::*, lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     exe_valid,
    output logic     exe_ready,
    input  exe_req_s req,
    output logic     rsp_valid,
    output mem_rsp_s rsp,
    output axi_ar_s  ar,
    output logic     arvalid,
    input  logic     arready,
    input  axi_r_s   r,
    input  logic     rvalid,
    output logic     rready,
    output axi_aw_s  aw,
    output logic     awvalid,
    input  logic     awready,
    output axi_w_s   w,
    output logic     wvalid,
    input  logic     wready,
    input  axi_b_s   b,
    input  logic     bvalid,
    output logic     bready
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_ADDR,
        S_READ_DATA,
        S_WRITE_REQ,
        S_WRITE_RESP
    } state_e;

    state_e     state;
    exe_req_s   cur; // request in flight.
    logic       accept;
    logic       is_sdram;
    axi_size_e  size;
    axi_burst_e burst;

    function automatic mem_rsp_s build_rsp(exe_req_s q, logic [31:0] data, logic fault);
        mem_rsp_s m;
        m.rd          = q.rd;
        m.width       = q.width;
        m.is_unsigned = q.is_unsigned;
        m.illegal     = q.illegal;
        m.offset      = q.addr[1:0];
        m.rdata       = data;
        m.fault       = fault;
        m.is_load     = (q.op == OP_LOAD);
        return m;
    endfunction

    assign exe_ready = (state == S_IDLE);
    assign accept    = exe_valid && exe_ready;
    assign is_sdram  = (req.addr >= `LSU_SDRAM_BASE) && (req.addr <= `LSU_SDRAM_END);
    assign burst     = is_sdram ? AXI_BURST_INCR : AXI_BURST_FIXED;

    always_comb begin
        case (req.width)
            MW_BYTE: size = AXI_SIZE_BYTE;
            MW_HALF: size = AXI_SIZE_HALF;
            default: size = AXI_SIZE_WORD;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (exe_valid) begin
                        case (req.op)
                            OP_LOAD: begin
                                arvalid <= 1'b1;
                                state   <= S_READ_ADDR;
                            end
                            OP_STORE: begin
                                awvalid <= 1'b1;
                                wvalid  <= 1'b1;
                                state   <= S_WRITE_REQ;
                            end
                            default: rsp_valid <= 1'b1; // no bus access.
                        endcase
                    end
                end
                S_READ_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= S_READ_DATA;
                    end
                end
                S_READ_DATA: begin
                    if (rvalid) begin
                        rready    <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                S_WRITE_REQ: begin
                    // aw and w must complete in the same cycle.
                    if (awready && wready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b0;
                        bready  <= 1'b1;
                        state   <= S_WRITE_RESP;
                    end
                end
                S_WRITE_RESP: begin
                    if (bvalid) begin
                        bready    <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur      <= req;
            ar.addr  <= req.addr;
            ar.id    <= `LSU_AXI_ID;
            ar.len   <= 8'd0; // single beat.
            ar.size  <= size;
            ar.burst <= burst;
            aw.addr  <= req.addr;
            aw.id    <= `LSU_AXI_ID;
            aw.len   <= 8'd0;
            aw.size  <= size;
            aw.burst <= burst;
            w.data   <= req.wdata;
            w.strb   <= req.wstrb;
            w.last   <= 1'b1;
        end
        if (accept && req.op == OP_NONE) begin
            rsp <= build_rsp(req, 32'd0, 1'b0);
        end else if (state == S_READ_DATA && rvalid) begin
            rsp <= build_rsp(cur, r.data, r.resp != 2'b00);
        end else if (state == S_WRITE_RESP && bvalid) begin
            rsp <= build_rsp(cur, 32'd0, b.resp != 2'b00);
        end
    end

endmodule

// File: rtl/addr_exec.sv
`timescale 1ns/1ns

module addr_exec
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dec_valid,
    output logic      dec_ready,
    input  dec_ctrl_s dec,
    output logic      exe_valid,
    input  logic      exe_ready,
    output exe_req_s  req
);
    logic [31:0] addr;
    logic [1:0]  offset;
    logic [3:0]  strb;

    assign addr      = dec.rs1_val + dec.imm;
    assign offset    = addr[1:0];
    assign dec_ready = !exe_valid || exe_ready;

    always_comb begin
        case (dec.width)
            MW_BYTE: strb = 4'b0001 << offset;
            MW_HALF: strb = 4'b0011 << offset;
            default: strb = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (dec_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            req.op          <= dec.op;
            req.width       <= dec.width;
            req.is_unsigned <= dec.is_unsigned;
            req.illegal     <= dec.illegal;
            req.rd          <= dec.rd;
            req.addr        <= addr;
            req.wdata       <= dec.rs2_val << {offset, 3'b000}; // move to byte lane.
            req.wstrb       <= (dec.op == OP_STORE) ? strb : 4'b0000;
        end
    end

endmodule

// File: rtl/mem_decode.sv
`timescale 1ns/1ns

module mem_decode
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] inst,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic        dec_valid,
    input  logic        dec_ready,
    output dec_ctrl_s   dec
);
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    dec_ctrl_s  dec_next;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign in_ready = !dec_valid || dec_ready; // empty or draining.

    always_comb begin
        dec_next         = '0;
        dec_next.op      = OP_NONE;
        dec_next.width   = MW_WORD;
        dec_next.illegal = 1'b1; // cleared below on a match.
        dec_next.rs1_val = rs1_val;
        dec_next.rs2_val = rs2_val;
        case (funct3[1:0])
            2'b00:   dec_next.width = MW_BYTE;
            2'b01:   dec_next.width = MW_HALF;
            default: dec_next.width = MW_WORD;
        endcase
        if (opcode == OPC_LOAD) begin
            dec_next.imm = {{20{inst[31]}}, inst[31:20]};
            if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010 ||
                funct3 == 3'b100 || funct3 == 3'b101) begin
                dec_next.op          = OP_LOAD;
                dec_next.illegal     = 1'b0;
                dec_next.is_unsigned = funct3[2]; // lbu, lhu.
                dec_next.rd          = inst[11:7];
            end
        end else if (opcode == OPC_STORE) begin
            dec_next.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
                dec_next.op      = OP_STORE;
                dec_next.illegal = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec <= dec_next;
        end
    end

endmodule

// File: rtl/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        MW_BYTE = 2'd0,
        MW_HALF = 2'd1,
        MW_WORD = 2'd2
    } mem_width_e;

    // decode to execute.
    typedef struct packed {
        mem_op_e              op;
        mem_width_e           width;
        logic                 is_unsigned;
        logic                 illegal;
        logic [4:0]           rd;
        logic [`LSU_XLEN-1:0] imm;
        logic [`LSU_XLEN-1:0] rs1_val;
        logic [`LSU_XLEN-1:0] rs2_val;
    } dec_ctrl_s;

    // execute to bus engine.
    typedef struct packed {
        mem_op_e                op;
        mem_width_e             width;
        logic                   is_unsigned;
        logic                   illegal;
        logic [4:0]             rd;
        logic [31:0]            addr;
        logic [`LSU_XLEN-1:0]   wdata;
        logic [`LSU_XLEN/8-1:0] wstrb;
    } exe_req_s;

    // bus engine to result stage, rdata still raw.
    typedef struct packed {
        logic [4:0]           rd;
        mem_width_e           width;
        logic                 is_unsigned;
        logic                 illegal;
        logic [1:0]           offset;
        logic [`LSU_XLEN-1:0] rdata;
        logic                 fault;
        logic                 is_load;
    } mem_rsp_s;

    typedef struct packed {
        logic [4:0]           rd;
        logic                 rd_we;
        logic [`LSU_XLEN-1:0] data;
        logic                 fault;
        logic                 illegal;
    } wb_s;

endpackage

// File: rtl/axi_pkg.sv
`include "lsu_cfg.svh"

package axi_pkg;

    typedef enum logic [2:0] {
        AXI_SIZE_BYTE = 3'd0,
        AXI_SIZE_HALF = 3'd1,
        AXI_SIZE_WORD = 3'd2
    } axi_size_e;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01
    } axi_burst_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        axi_size_e   size;
        axi_burst_e  burst;
    } axi_ar_s;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        axi_size_e   size;
        axi_burst_e  burst;
    } axi_aw_s;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   data;
        logic [`LSU_XLEN/8-1:0] strb;
        logic                   last;
    } axi_w_s;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_s;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] data;
        logic [1:0]           resp;
        logic                 last;
        logic [3:0]           id;
    } axi_r_s;

endpackage

// File: rtl/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// fixed transaction id on awid and arid.
`define LSU_AXI_ID      4'h0

// addresses in this window get incr bursts.
`define LSU_SDRAM_BASE  32'hA000_0000
`define LSU_SDRAM_END   32'hBFFF_FFFF

`define LSU_XLEN        32

`endif
